/* mfPkg.sv */
// Shared widths, payload types and the APB register map of the matched filter.
// RTL and testbench refer to every item here by its scoped name.
package mfPkg;

	// Width of one real or imaginary sample part.
	localparam int dataWidth = 16;

	// Width of the filter accumulator and of the filter outputs.
	localparam int accWidth = 40;

	// APB bus widths. One APB data word carries exactly one memory word.
	localparam int apbAddrWidth = 12;
	localparam int apbDataWidth = 2 * dataWidth;

	// Signed real sample.
	typedef logic signed [dataWidth-1:0] sampleT;

	// Complex coefficient with the real part in the upper half.
	typedef struct packed {
		sampleT re;
		sampleT im;
	} coeffT;

	// Raw memory word, the same size as a coefficient.
	typedef logic [2*dataWidth-1:0] memWordT;

	// Register word addresses.
	localparam logic [apbAddrWidth-1:0] regCtrl = 12'h000;
	localparam logic [apbAddrWidth-1:0] regStatus = 12'h001;
	localparam logic [apbAddrWidth-1:0] regLength = 12'h002;

	// Memory word i sits at memBase plus i.
	localparam logic [apbAddrWidth-1:0] memBase = 12'h100;

endpackage

/* sampleMemory.sv */
// Shared coefficient and sample store of the matched filter.
// The host fills it through the register block, and the fetchers read it
// through the arbiter with one cycle of read latency.
`timescale 1ns/1ps

module sampleMemory #(
	parameter int memDepth = 64,
	parameter int addrWidth = 6
) (
	input logic clock,
	input logic we,
	input logic [addrWidth-1:0] waddr,
	input mfPkg::memWordT wdata,
	input logic [addrWidth-1:0] raddr,
	output mfPkg::memWordT rdata
);

	// The storage array. The host loads it over APB before each run.
	mfPkg::memWordT mem [memDepth];

	// Host writes land at the next rising edge.
	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read.
	// The word addressed in one cycle appears on rdata in the next.
	always_ff @(posedge clock) begin
		rdata <= mem[raddr];
	end

endmodule

/* memArbiter.sv */
// Round-robin arbiter that shares the memory read port between two fetchers.
// Port A serves the coefficient fetcher and port B the sample fetcher.
// Read data returns to the granted requester exactly one cycle after the grant.
`timescale 1ns/1ps

module memArbiter #(
	parameter int addrWidth = 6
) (
	input logic clock,
	input logic rst,
	input logic reqA,
	input logic reqB,
	input logic [addrWidth-1:0] addrA,
	input logic [addrWidth-1:0] addrB,
	output logic gntA,
	output logic gntB,
	output logic rvalidA,
	output logic rvalidB,
	output mfPkg::memWordT rdataA,
	output mfPkg::memWordT rdataB,
	input mfPkg::memWordT rdata,
	output logic [addrWidth-1:0] raddr
);

	// Set when port B held the last grant, so port A wins the next tie.
	logic lastB;

	// Owner tag of the read that is in flight in the memory.
	logic ownerValid;
	logic ownerB;

	// A lone request is always granted.
	// When both ask, the port that did not win last time gets the grant.
	assign gntA = reqA && (!reqB || lastB);
	assign gntB = reqB && (!reqA || !lastB);

	// The granted address goes straight to the memory in the same cycle.
	assign raddr = gntB ? addrB : addrA;

	always_ff @(posedge clock) begin
		if (rst) begin
			lastB <= 1'b0;
			ownerValid <= 1'b0;
			ownerB <= 1'b0;
		end else begin
			if (gntA || gntB) begin
				lastB <= gntB;
			end
			ownerValid <= gntA || gntB;
			ownerB <= gntB;
		end
	end

	// Steer the returning word to the port that issued the read.
	assign rvalidA = ownerValid && !ownerB;
	assign rvalidB = ownerValid && ownerB;
	assign rdataA = rvalidA ? rdata : '0;
	assign rdataB = rvalidB ? rdata : '0;

endmodule

/* streamFetcher.sv */
// Reads a run of consecutive memory words and offers each as a stream payload.
// The payload type sets how many low-order bits of the word are kept.
// Start loads the base address and word count, and a new start restarts the run.
`timescale 1ns/1ps

module streamFetcher #(
	parameter type payloadT = mfPkg::sampleT,
	parameter int addrWidth = 6
) (
	input logic clock,
	input logic rst,
	input logic start,
	input logic [addrWidth-1:0] base,
	input logic [addrWidth-1:0] count,
	output logic req,
	output logic [addrWidth-1:0] addr,
	input logic gnt,
	input logic rvalid,
	input mfPkg::memWordT rdata,
	output logic valid,
	input logic ready,
	output payloadT payload
);

	// Request, wait for read data, then hold the payload until it is taken.
	typedef enum logic [1:0] {
		idleSt,
		reqSt,
		waitSt,
		holdSt
	} stateT;

	stateT state;

	// Words still to deliver, counting the one in progress.
	logic [addrWidth-1:0] remaining;

	// A read is requested only in reqSt, so at most one is outstanding.
	assign req = (state == reqSt);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= idleSt;
			valid <= 1'b0;
			addr <= '0;
			remaining <= '0;
		end else if (start) begin
			addr <= base;
			remaining <= count;
			valid <= 1'b0;
			state <= (count != '0) ? reqSt : idleSt;
		end else begin
			case (state)
				reqSt: begin
					if (gnt) begin
						state <= waitSt;
					end
				end
				waitSt: begin
					if (rvalid) begin
						valid <= 1'b1;
						state <= holdSt;
					end
				end
				holdSt: begin
					// A stalled consumer keeps the payload and blocks the next read.
					if (ready) begin
						valid <= 1'b0;
						addr <= addr + 1'b1;
						remaining <= remaining - 1'b1;
						state <= (remaining == 1) ? idleSt : reqSt;
					end
				end
				default: begin
					state <= idleSt;
				end
			endcase
		end
	end

	// Capture the low-order bits of the returned word.
	always_ff @(posedge clock) begin
		if (state == waitSt && rvalid && !start) begin
			payload <= payloadT'(rdata[$bits(payloadT)-1:0]);
		end
	end

endmodule

/* complexFir.sv */
// Complex-coefficient FIR matched filter with a real input stream.
// Coefficients load serially after start; samples are accepted once all taps hold one.
// Each accepted sample gives one registered complex output a cycle later.
// The filter needs at least two taps.
`timescale 1ns/1ps

module complexFir #(
	parameter int taps = 8
) (
	input logic clock,
	input logic rst,
	input logic start,
	input logic coeffValid,
	input mfPkg::coeffT coeffIn,
	input logic sampleValid,
	output logic sampleReady,
	input mfPkg::sampleT sampleIn,
	output logic outValid,
	output logic signed [mfPkg::accWidth-1:0] outRe,
	output logic signed [mfPkg::accWidth-1:0] outIm
);

	// Tap k holds c[k].
	mfPkg::coeffT coeffs [taps];

	// Entry k holds x[n-1-k] relative to the sample being accepted.
	mfPkg::sampleT hist [taps-1];

	// Number of coefficients loaded since start.
	logic [$clog2(taps+1)-1:0] loadCount;

	logic accept;
	logic signed [mfPkg::accWidth-1:0] sumRe;
	logic signed [mfPkg::accWidth-1:0] sumIm;

	assign sampleReady = (loadCount == taps);
	assign accept = sampleValid && sampleReady;

	always_ff @(posedge clock) begin
		if (rst || start) begin
			loadCount <= '0;
		end else if (coeffValid && !sampleReady) begin
			loadCount <= loadCount + 1'b1;
		end
	end

	// New coefficients enter at the top and move down one tap per load.
	// After taps loads the first one has reached tap 0.
	always_ff @(posedge clock) begin
		if (coeffValid && !sampleReady && !start) begin
			coeffs[taps-1] <= coeffIn;
			for (int k = 0; k < taps - 1; k++) begin
				coeffs[k] <= coeffs[k+1];
			end
		end
	end

	// Sample history, zeroed at start so a run sees no earlier input.
	always_ff @(posedge clock) begin
		if (start) begin
			for (int k = 0; k < taps - 1; k++) begin
				hist[k] <= '0;
			end
		end else if (accept) begin
			hist[0] <= sampleIn;
			for (int k = 1; k < taps - 1; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	// The input is real, so each part is a plain sum of products.
	// Both factors are widened to the accumulator before they are multiplied.
	always_comb begin
		sumRe = mfPkg::accWidth'(coeffs[0].re) * mfPkg::accWidth'(sampleIn);
		sumIm = mfPkg::accWidth'(coeffs[0].im) * mfPkg::accWidth'(sampleIn);
		for (int k = 1; k < taps; k++) begin
			sumRe = sumRe + mfPkg::accWidth'(coeffs[k].re) * mfPkg::accWidth'(hist[k-1]);
			sumIm = sumIm + mfPkg::accWidth'(coeffs[k].im) * mfPkg::accWidth'(hist[k-1]);
		end
	end

	always_ff @(posedge clock) begin
		if (rst || start) begin
			outValid <= 1'b0;
		end else begin
			outValid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			outRe <= sumRe;
			outIm <= sumIm;
		end
	end

endmodule

/* apbRegs.sv */
// APB slave with the control, status and length registers of the matched filter.
// Writes inside the memory window go straight to the sample memory while idle.
// Every access completes in its access phase; pslverr flags dropped accesses.
`timescale 1ns/1ps

module apbRegs #(
	parameter int taps = 8,
	parameter int memDepth = 64,
	parameter int addrWidth = 6
) (
	input logic clock,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mfPkg::apbAddrWidth-1:0] paddr,
	input logic [mfPkg::apbDataWidth-1:0] pwdata,
	output logic [mfPkg::apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic memWe,
	output logic [addrWidth-1:0] memWaddr,
	output mfPkg::memWordT memWdata,
	output logic start,
	output logic [addrWidth-1:0] length,
	input logic outValid
);

	logic access, wrAccess, rdAccess;
	logic isCtrl, isStatus, isLength, inWindow, mapped;
	logic lengthOk, wrErr, rdErr, startWr;
	logic busy, done;
	logic [addrWidth-1:0] outCount;

	assign access = psel && penable;
	assign wrAccess = access && pwrite;
	assign rdAccess = access && !pwrite;
	assign isCtrl = (paddr == mfPkg::regCtrl);
	assign isStatus = (paddr == mfPkg::regStatus);
	assign isLength = (paddr == mfPkg::regLength);
	assign inWindow = (paddr >= mfPkg::memBase) && (paddr < mfPkg::memBase + memDepth);
	assign mapped = isCtrl || isStatus || isLength || inWindow;
	assign lengthOk = (pwdata != '0) && (pwdata <= memDepth - taps);
	// Memory and length are frozen during a run. The window cannot be read back.
	assign wrErr = !mapped || (inWindow && busy) || (isLength && (busy || !lengthOk));
	assign rdErr = !mapped || inWindow;
	assign pslverr = access && (pwrite ? wrErr : rdErr);
	assign pready = 1'b1;
	assign startWr = wrAccess && isCtrl && pwdata[0];

	always_comb begin
		prdata = '0;
		if (rdAccess && isStatus) begin
			prdata[1:0] = {done, busy};
		end else if (rdAccess && isLength) begin
			prdata[addrWidth-1:0] = length;
		end
	end

	assign memWe = wrAccess && inWindow && !busy;
	assign memWaddr = addrWidth'(paddr - mfPkg::memBase);
	assign memWdata = mfPkg::memWordT'(pwdata);

	// Start clears done and the output count; the last expected output ends the run.
	always_ff @(posedge clock) begin
		if (rst) begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			length <= addrWidth'(1);
			outCount <= '0;
		end else begin
			start <= startWr;
			if (wrAccess && isLength && !wrErr) begin
				length <= addrWidth'(pwdata);
			end
			if (startWr) begin
				busy <= 1'b1;
				done <= 1'b0;
				outCount <= '0;
			end else if (busy && outValid) begin
				outCount <= outCount + 1'b1;
				if (outCount + 1'b1 == length) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

/* matchedFilterTop.sv */
// Top level of the pulse-compression block.
// The host loads memory and starts runs over APB; the filter output leaves on loose ports.
// Two fetchers share the memory read port through a round-robin arbiter.
`timescale 1ns/1ps

module matchedFilterTop #(
	parameter int taps = 8,
	parameter int memDepth = 64
) (
	input logic clock,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mfPkg::apbAddrWidth-1:0] paddr,
	input logic [mfPkg::apbDataWidth-1:0] pwdata,
	output logic [mfPkg::apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic outValid,
	output logic signed [mfPkg::accWidth-1:0] outRe,
	output logic signed [mfPkg::accWidth-1:0] outIm
);

	localparam int addrWidth = $clog2(memDepth);

	logic memWe, start;
	logic [addrWidth-1:0] memWaddr, length, raddr;
	mfPkg::memWordT memWdata, rdata, rdataC, rdataS;
	logic reqC, reqS, gntC, gntS, rvalidC, rvalidS;
	logic [addrWidth-1:0] addrC, addrS;
	logic coeffValid, sampleValid, sampleReady;
	mfPkg::coeffT coeffPayload;
	mfPkg::sampleT samplePayload;

	apbRegs #(.taps(taps), .memDepth(memDepth), .addrWidth(addrWidth)) regs (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.pslverr, .memWe, .memWaddr, .memWdata, .start, .length, .outValid);

	sampleMemory #(.memDepth(memDepth), .addrWidth(addrWidth)) mem (
		.clock, .we(memWe), .waddr(memWaddr), .wdata(memWdata), .raddr, .rdata);

	memArbiter #(.addrWidth(addrWidth)) arb (
		.clock, .rst, .reqA(reqC), .reqB(reqS), .addrA(addrC), .addrB(addrS),
		.gntA(gntC), .gntB(gntS), .rvalidA(rvalidC), .rvalidB(rvalidS),
		.rdataA(rdataC), .rdataB(rdataS), .rdata, .raddr);

	// Coefficients sit at words 0 to taps-1 and the filter always takes them.
	streamFetcher #(.payloadT(mfPkg::coeffT), .addrWidth(addrWidth)) coeffFetch (
		.clock, .rst, .start, .base('0), .count(addrWidth'(taps)), .req(reqC), .addr(addrC),
		.gnt(gntC), .rvalid(rvalidC), .rdata(rdataC), .valid(coeffValid), .ready(1'b1),
		.payload(coeffPayload));

	// Samples follow the coefficients in memory.
	streamFetcher #(.payloadT(mfPkg::sampleT), .addrWidth(addrWidth)) sampleFetch (
		.clock, .rst, .start, .base(addrWidth'(taps)), .count(length), .req(reqS),
		.addr(addrS), .gnt(gntS), .rvalid(rvalidS), .rdata(rdataS), .valid(sampleValid),
		.ready(sampleReady), .payload(samplePayload));

	complexFir #(.taps(taps)) fir (
		.clock, .rst, .start, .coeffValid, .coeffIn(coeffPayload), .sampleValid,
		.sampleReady, .sampleIn(samplePayload), .outValid, .outRe, .outIm);

endmodule

/* tbMatchedFilter.sv */
// Self-checking testbench for the matched filter top level.
// It fills the sample memory over APB, starts runs and checks every filter output
// against a convolution model kept in the testbench. Error checks cover the
// busy protection and the range checks of the register block.
`timescale 1ns/1ps

module tbMatchedFilter;

	localparam int taps = 8;
	localparam int memDepth = 64;
	localparam int period = 40;
	localparam int numRuns = 5;

	logic clock;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [mfPkg::apbAddrWidth-1:0] paddr;
	logic [mfPkg::apbDataWidth-1:0] pwdata;
	logic [mfPkg::apbDataWidth-1:0] prdata;
	logic pready;
	logic pslverr;
	logic outValid;
	logic signed [mfPkg::accWidth-1:0] outRe;
	logic signed [mfPkg::accWidth-1:0] outIm;

	// Testbench copy of the memory contents, updated only by accepted writes.
	mfPkg::memWordT model [memDepth];

	// Expected outputs in arrival order.
	logic signed [mfPkg::accWidth-1:0] expRe [$];
	logic signed [mfPkg::accWidth-1:0] expIm [$];

	int outCount;
	int errorCount;
	int checkCount;
	int testCount;
	int errorsAtStart;
	int lastLen;

	matchedFilterTop #(.taps(taps), .memDepth(memDepth)) DUT (
		.clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.pslverr, .outValid, .outRe, .outIm);

	always #(period / 2) clock = ~clock;

	task automatic checkOutput(input string what, input logic signed [mfPkg::accWidth-1:0] got,
			input logic signed [mfPkg::accWidth-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkStatus(input string what, input logic [mfPkg::apbDataWidth-1:0] got,
			input logic [mfPkg::apbDataWidth-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAILED at %0t ns: %s reads %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkErr(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAILED at %0t ns: %s gave pslverr %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Every APB access must complete in its access phase.
	task automatic checkReady(input logic got);
		checkCount++;
		if (got !== 1'b1) begin
			errorCount++;
			$display("FAILED at %0t ns: pready is %b in the access phase, expected 1",
				$time, got);
		end
	endtask

	// One APB write. The response is sampled in the middle of the access phase.
	task automatic apbWrite(input logic [mfPkg::apbAddrWidth-1:0] addr,
			input logic [mfPkg::apbDataWidth-1:0] data, output logic err);
		@(posedge clock);
		#2;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clock);
		#2;
		penable = 1'b1;
		#(period / 2);
		err = pslverr;
		checkReady(pready);
		@(posedge clock);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input logic [mfPkg::apbAddrWidth-1:0] addr,
			output logic [mfPkg::apbDataWidth-1:0] data, output logic err);
		@(posedge clock);
		#2;
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clock);
		#2;
		penable = 1'b1;
		#(period / 2);
		data = prdata;
		err = pslverr;
		checkReady(pready);
		@(posedge clock);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Writes one memory word while idle and mirrors it in the model.
	task automatic writeWord(input int index, input mfPkg::memWordT data);
		logic err;
		apbWrite(mfPkg::apbAddrWidth'(mfPkg::memBase + index), data, err);
		checkErr("memory write", err, 1'b0);
		model[index] = data;
	endtask

	// y[n] is the sum of c[k] * x[n-k]; samples before the run count as zero.
	task automatic queueExpected(input int len);
		longint re;
		longint im;
		mfPkg::coeffT c;
		mfPkg::sampleT x;
		for (int n = 0; n < len; n++) begin
			re = 0;
			im = 0;
			for (int k = 0; k < taps; k++) begin
				if (n - k >= 0) begin
					c = mfPkg::coeffT'(model[k]);
					x = mfPkg::sampleT'(model[taps + n - k][mfPkg::dataWidth-1:0]);
					re += longint'(c.re) * longint'(x);
					im += longint'(c.im) * longint'(x);
				end
			end
			expRe.push_back(re[mfPkg::accWidth-1:0]);
			expIm.push_back(im[mfPkg::accWidth-1:0]);
		end
	endtask

	// Loads random data and runs the filter once. A spike position of zero or more
	// makes every sample zero except that one. With protect set, writes are tried
	// while the run is busy and must be refused.
	task automatic runFilter(input int len, input int spikePos, input bit protect);
		logic err;
		logic [mfPkg::apbDataWidth-1:0] rd;
		mfPkg::memWordT w;
		mfPkg::sampleT spike;
		spike = mfPkg::sampleT'($urandom);
		if (spike == 0) begin
			spike = 1;
		end
		for (int k = 0; k < taps; k++) begin
			writeWord(k, $urandom);
		end
		for (int n = 0; n < len; n++) begin
			w = $urandom;
			// The upper bits stay random and the fetcher ignores them.
			if (spikePos >= 0) begin
				w[mfPkg::dataWidth-1:0] = (n == spikePos) ? spike : '0;
			end
			writeWord(taps + n, w);
		end
		apbWrite(mfPkg::regLength, mfPkg::apbDataWidth'(len), err);
		checkErr("length write", err, 1'b0);
		lastLen = len;
		queueExpected(len);
		outCount = 0;
		apbWrite(mfPkg::regCtrl, 32'h1, err);
		checkErr("start write", err, 1'b0);
		// Busy is set and the done flag of the previous run is gone.
		apbRead(mfPkg::regStatus, rd, err);
		checkStatus("status after start", rd, 32'h1);
		if (protect) begin
			apbWrite(mfPkg::apbAddrWidth'(mfPkg::memBase + taps + $urandom % len), $urandom, err);
			checkErr("memory write while busy", err, 1'b1);
			apbWrite(mfPkg::regLength, 32'h1, err);
			checkErr("length write while busy", err, 1'b1);
		end
		wait (outCount == len);
		apbRead(mfPkg::regStatus, rd, err);
		checkStatus("status after run", rd, 32'h2);
		checkCount++;
		if (outCount != len || expRe.size() != 0) begin
			errorCount++;
			$display("Run of %0d samples gave %0d outputs", len, outCount);
		end
	endtask

	task automatic startTest();
		errorsAtStart = errorCount;
	endtask

	task automatic reportTest(input string name);
		testCount++;
		$display("[%0t ns] %s: %0d errors", $time, name, errorCount - errorsAtStart);
	endtask

	// Outputs are registered, so the falling edge sees them settled.
	always @(negedge clock) begin
		if (outValid) begin
			if (expRe.size() == 0) begin
				errorCount++;
				$display("Output at %0t ns arrived with no output expected", $time);
			end else begin
				checkOutput("outRe", outRe, expRe.pop_front());
				checkOutput("outIm", outIm, expIm.pop_front());
			end
			outCount++;
		end
	end

	// Each run gets memDepth times 20 clock periods, loading included.
	initial begin
		#(numRuns * memDepth * 20 * period);
		$display("Watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic err;
		logic [mfPkg::apbDataWidth-1:0] rd;
		int pos;
		void'($urandom(32'h6f63_134e));
		clock = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		outCount = 0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		lastLen = 1;
		repeat (16) @(posedge clock);
		#2;
		rst = 1'b0;

		startTest();
		runFilter(1 + $urandom % (memDepth - taps), -1, 1'b0);
		reportTest("random run with output count and status");

		startTest();
		runFilter(1 + $urandom % (memDepth - taps), -1, 1'b1);
		reportTest("busy protection");

		// All of these are tried while idle, so only the range checks apply.
		startTest();
		apbWrite(mfPkg::regLength, 32'h0, err);
		checkErr("zero length", err, 1'b1);
		apbWrite(mfPkg::regLength, mfPkg::apbDataWidth'(memDepth - taps + 1), err);
		checkErr("length above range", err, 1'b1);
		apbWrite(12'h050, $urandom, err);
		checkErr("unmapped write", err, 1'b1);
		apbRead(12'h0ff, rd, err);
		checkErr("unmapped read", err, 1'b1);
		apbRead(mfPkg::memBase, rd, err);
		checkErr("memory window read", err, 1'b1);
		checkStatus("memory window read data", rd, 32'h0);
		apbRead(mfPkg::regLength, rd, err);
		checkStatus("length after refused writes", rd, mfPkg::apbDataWidth'(lastLen));
		reportTest("range errors");

		startTest();
		runFilter(1 + $urandom % (memDepth - taps), -1, 1'b0);
		runFilter(1 + $urandom % (memDepth - taps), -1, 1'b0);
		reportTest("back-to-back runs");

		startTest();
		pos = $urandom % taps;
		runFilter(pos + taps + 3, pos, 1'b0);
		reportTest("sparse input");

		// A quiet stretch catches any stray output after the last run.
		repeat (2 * taps) @(posedge clock);
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
mfPkg.sv
sampleMemory.sv
memArbiter.sv
streamFetcher.sv
complexFir.sv
apbRegs.sv
matchedFilterTop.sv
tbMatchedFilter.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --timing
TOP = tbMatchedFilter
LIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(LIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(LIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
